// File: logic/uart_pkg.sv
// Shared UART frame constants, types and the parity function, imported by every RTL module
package uart_pkg;

	// Frame shape
	localparam int DATA_BITS = 8;
	localparam int STOP_BITS = 2;

	// 1 selects even parity, 0 selects odd parity
	localparam bit PARITY_EVEN = 1'b0;

	// Width of the clocks-per-symbol count
	localparam int SYM_COUNT_W = 24;

	typedef logic [SYM_COUNT_W-1:0] sym_count_t;
	typedef logic [DATA_BITS-1:0] uart_data_t;

	// Single-cycle points within one symbol
	typedef struct packed {
		logic setup;	// leading edge
		logic sample;	// symbol centre
		logic symend;	// last cycle of the symbol
	} sym_strobes_t;

	// What the receiver reports for one frame
	typedef struct packed {
		uart_data_t data;
		logic       parity;
		logic       parity_ok;
		logic       frame_error;
	} rx_result_t;

	// Symbol positions walked by both state machines
	typedef enum logic [2:0] {
		st_idle,
		st_start,
		st_data,
		st_parity,
		st_stop
	} frame_state_t;

	// Parity bit for a data byte
	function automatic logic calc_parity(input uart_data_t value);
		logic p;
		p = ^value;
		// Odd parity flips the plain XOR
		if (!PARITY_EVEN) begin
			p = ~p;
		end
		return p;
	endfunction

endpackage

// File: logic/uart_symbol_timer.sv
// Symbol timer that marks the setup, sample and end points of each UART symbol while running
`timescale 1ns/1ps

module uart_symbol_timer import uart_pkg::*; (
	input  logic         clk,
	input  logic         n_reset,
	input  logic         run,
	input  sym_count_t   clks_per_sym,
	output sym_strobes_t strobes
);

	sym_count_t count;
	sym_count_t half_sym;

	assign half_sym = clks_per_sym >> 1;

	// Strobes are registered, so each one trails its count value by a cycle
	always_ff @(posedge clk) begin
		if (n_reset || !run) begin
			count <= '0;
			strobes <= '0;
		end else begin
			strobes <= '0;
			if (count == '0) begin
				strobes.setup <= 1'b1;
				count <= count + 1'b1;
			end else if (count == half_sym - 1'b1) begin
				strobes.sample <= 1'b1;
				count <= count + 1'b1;
			end else if (count >= clks_per_sym - 1'b1) begin
				// Wrap for the next symbol of the frame
				strobes.symend <= 1'b1;
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

// File: logic/uart_receiver.sv
// UART receiver with line synchronizer, start-edge detect, parity and framing checks
`timescale 1ns/1ps

module uart_receiver import uart_pkg::*; (
	input  logic       clk,
	input  logic       n_reset,
	input  sym_count_t clks_per_sym,
	input  logic       rx,
	output logic       active,
	output logic       done,
	output rx_result_t result
);

	// Two-stage synchronizer plus one stage of history for edge detect
	logic rx_meta;
	logic rx_sync;
	logic rx_last;
	logic rx_falling;

	frame_state_t state;
	logic [2:0]   bit_idx;
	logic         run;
	sym_strobes_t strobes;

	uart_data_t rx_buf;
	logic       rx_parity_bit;
	logic       start_error;
	logic       rx_parity_calc;

	uart_symbol_timer u_timer (
		.clk          (clk),
		.n_reset      (n_reset),
		.run          (run),
		.clks_per_sym (clks_per_sym),
		.strobes      (strobes)
	);

	// Line idles high, so reset to 1 to avoid a false start edge
	always_ff @(posedge clk) begin
		if (n_reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_last <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_last <= rx_sync;
		end
	end

	assign rx_falling = rx_last & ~rx_sync;

	assign rx_parity_calc = calc_parity(rx_buf);

	always_ff @(posedge clk) begin
		if (n_reset) begin
			state <= st_idle;
			bit_idx <= '0;
			run <= 1'b0;
			active <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				st_idle: begin
					if (rx_falling) begin
						state <= st_start;
						run <= 1'b1;
						active <= 1'b1;
					end
				end
				st_start: begin
					// A start bit that reads high at its centre is a framing fault
					if (strobes.sample) begin
						start_error <= rx_sync;
					end else if (strobes.symend) begin
						state <= st_data;
						bit_idx <= '0;
					end
				end
				st_data: begin
					if (strobes.sample) begin
						rx_buf[bit_idx] <= rx_sync;
					end else if (strobes.symend) begin
						if (bit_idx == 3'(DATA_BITS - 1)) begin
							state <= st_parity;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				st_parity: begin
					if (strobes.sample) begin
						rx_parity_bit <= rx_sync;
					end else if (strobes.symend) begin
						state <= st_stop;
						bit_idx <= '0;
					end
				end
				st_stop: begin
					// Only the first stop bit is checked, then back to idle mid-bit
					if (strobes.sample) begin
						result.data <= rx_buf;
						result.parity <= rx_parity_calc;
						result.parity_ok <= (rx_parity_calc == rx_parity_bit);
						result.frame_error <= start_error | ~rx_sync;
						done <= 1'b1;
						active <= 1'b0;
						run <= 1'b0;
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
					run <= 1'b0;
					active <= 1'b0;
				end
			endcase
		end
	end

endmodule

// File: logic/uart_transmitter.sv
// UART transmitter that sends a latched byte with start, parity and stop bits on a trigger
`timescale 1ns/1ps

module uart_transmitter import uart_pkg::*; (
	input  logic       clk,
	input  logic       n_reset,
	input  sym_count_t clks_per_sym,
	input  uart_data_t data,
	input  logic       trigger,
	output logic       tx,
	output logic       active,
	output logic       done
);

	frame_state_t state;
	logic [2:0]   bit_idx;
	logic         run;
	sym_strobes_t strobes;

	// Byte held for the whole frame
	uart_data_t tx_buf;
	logic       tx_parity;

	uart_symbol_timer u_timer (
		.clk          (clk),
		.n_reset      (n_reset),
		.run          (run),
		.clks_per_sym (clks_per_sym),
		.strobes      (strobes)
	);

	assign tx_parity = calc_parity(tx_buf);

	always_ff @(posedge clk) begin
		if (n_reset) begin
			state <= st_idle;
			bit_idx <= '0;
			run <= 1'b0;
			tx <= 1'b1;
			active <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				st_idle: begin
					tx <= 1'b1;
					// Triggers only count here, so a busy trigger is dropped
					if (trigger) begin
						tx_buf <= data;
						tx <= 1'b0;
						run <= 1'b1;
						active <= 1'b1;
						state <= st_start;
					end
				end
				st_start: begin
					if (strobes.setup) begin
						tx <= 1'b0;
					end else if (strobes.symend) begin
						state <= st_data;
						bit_idx <= '0;
					end
				end
				st_data: begin
					// LSB goes out first
					if (strobes.setup) begin
						tx <= tx_buf[bit_idx];
					end else if (strobes.symend) begin
						if (bit_idx == 3'(DATA_BITS - 1)) begin
							state <= st_parity;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				st_parity: begin
					if (strobes.setup) begin
						tx <= tx_parity;
					end else if (strobes.symend) begin
						state <= st_stop;
						bit_idx <= '0;
					end
				end
				st_stop: begin
					if (strobes.setup) begin
						tx <= 1'b1;
					end else if (strobes.symend) begin
						if (bit_idx == 3'(STOP_BITS - 1)) begin
							done <= 1'b1;
							active <= 1'b0;
							run <= 1'b0;
							state <= st_idle;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				default: begin
					state <= st_idle;
					run <= 1'b0;
					tx <= 1'b1;
					active <= 1'b0;
				end
			endcase
		end
	end

endmodule

// File: logic/uart_full_duplex.sv
// Full-duplex UART top level with an independent receiver and transmitter
`timescale 1ns/1ps

module uart_full_duplex import uart_pkg::*; (
	input  logic       clk,
	input  logic       n_reset,
	input  sym_count_t clks_per_sym,
	input  logic       rx,
	input  uart_data_t tx_data,
	input  logic       tx_trigger,
	output logic       tx,
	output logic       tx_active,
	output logic       tx_done,
	output logic       rx_active,
	output logic       rx_done,
	output rx_result_t rx_result
);

	// Raw rx goes straight in, the receiver does its own synchronizing
	uart_receiver u_rx (
		.clk          (clk),
		.n_reset      (n_reset),
		.clks_per_sym (clks_per_sym),
		.rx           (rx),
		.active       (rx_active),
		.done         (rx_done),
		.result       (rx_result)
	);

	uart_transmitter u_tx (
		.clk          (clk),
		.n_reset      (n_reset),
		.clks_per_sym (clks_per_sym),
		.data         (tx_data),
		.trigger      (tx_trigger),
		.tx           (tx),
		.active       (tx_active),
		.done         (tx_done)
	);

endmodule

// File: tests/uart_full_duplex_sva.sv
// Assertions on the UART top-level strobes and transmit line, bound into the DUT
`timescale 1ns/1ps

module uart_full_duplex_sva (
	input logic clk,
	input logic n_reset,
	input logic tx,
	input logic tx_active,
	input logic tx_done,
	input logic rx_done
);

	// Idle transmitter holds the line high
	property tx_idle_high;
		@(posedge clk) disable iff (n_reset) !tx_active |-> tx;
	endproperty

	property tx_done_single;
		@(posedge clk) disable iff (n_reset) tx_done |=> !tx_done;
	endproperty

	property rx_done_single;
		@(posedge clk) disable iff (n_reset) rx_done |=> !rx_done;
	endproperty

	// End of frame and drop of tx_active go together, both ways
	property tx_done_ends_frame;
		@(posedge clk) disable iff (n_reset) tx_done |-> $fell(tx_active);
	endproperty

	property tx_fall_has_done;
		@(posedge clk) disable iff (n_reset) $fell(tx_active) |-> tx_done;
	endproperty

	assert property (tx_idle_high) else $error("tx low while the transmitter is idle");
	assert property (tx_done_single) else $error("tx_done held for two cycles");
	assert property (rx_done_single) else $error("rx_done held for two cycles");
	assert property (tx_done_ends_frame) else $error("tx_done without tx_active falling");
	assert property (tx_fall_has_done) else $error("tx_active fell without tx_done");

endmodule

bind uart_full_duplex uart_full_duplex_sva u_sva (
	.clk       (clk),
	.n_reset   (n_reset),
	.tx        (tx),
	.tx_active (tx_active),
	.tx_done   (tx_done),
	.rx_done   (rx_done)
);

// File: tests/uart_full_duplex_tb.sv
// Testbench for the UART transceiver that runs the case file and checks every frame
`timescale 1ns/1ps

module uart_full_duplex_tb import uart_pkg::*; ();

	localparam string CASE_FILE = "tests/uart_cases.txt";

	logic       clk;
	logic       n_reset;
	sym_count_t clks_per_sym;
	logic       rx;
	uart_data_t tx_data;
	logic       tx_trigger;
	logic       tx;
	logic       tx_active;
	logic       tx_done;
	logic       rx_active;
	logic       rx_done;
	rx_result_t rx_result;

	int         fd;
	string      line;
	byte        op;
	int         cps;
	int         pcor;
	int         scor;
	int         fields;
	uart_data_t data;
	int         case_num;

	uart_full_duplex uut (
		.clk          (clk),
		.n_reset      (n_reset),
		.clks_per_sym (clks_per_sym),
		.rx           (rx),
		.tx_data      (tx_data),
		.tx_trigger   (tx_trigger),
		.tx           (tx),
		.tx_active    (tx_active),
		.tx_done      (tx_done),
		.rx_active    (rx_active),
		.rx_done      (rx_done),
		.rx_result    (rx_result)
	);

	always #20 clk = ~clk;

	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopping after the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("ERR time=%0t %s got=%0h expected=%0h", $time, name, got, expected);
			abort_run();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t: %s did not arrive in time", $time, what);
		abort_run();
	endtask

	// XOR of the data bits, flipped for odd parity
	function automatic logic parity_rule(input uart_data_t value);
		int   ones;
		logic p;
		ones = 0;
		for (int i = 0; i < DATA_BITS; i++) begin
			if (value[i]) begin
				ones++;
			end
		end
		p = ones[0];
		if (!PARITY_EVEN) begin
			p = ~p;
		end
		return p;
	endfunction

	// Bit-bang one frame onto rx and check the receiver's result
	task automatic run_rx_case(input int sym, input uart_data_t value, input int bad_parity,
			input int bad_stop);
		logic [10:0] frame;
		rx_result_t  got;
		logic        seen;
		logic        active_at_done;
		int          limit;
		int          n;
		frame[0] = 1'b0;
		frame[8:1] = value;
		frame[9] = parity_rule(value) ^ (bad_parity != 0);
		frame[10] = (bad_stop == 0);
		seen = 1'b0;
		active_at_done = 1'b0;
		got = '0;
		for (int cyc = 0; cyc < 11 * sym; cyc++) begin
			rx = frame[cyc / sym];
			// With long symbols rx_done lands inside the stop bit
			if (rx_done && !seen) begin
				seen = 1'b1;
				got = rx_result;
				active_at_done = rx_active;
			end
			if (cyc == 2 * sym) begin
				check_value("rx_active", 32'(rx_active), 32'd1);
			end
			@(negedge clk);
		end
		rx = 1'b1;
		limit = 16 * sym + 32;
		n = 0;
		while (!seen) begin
			if (rx_done) begin
				seen = 1'b1;
				got = rx_result;
				active_at_done = rx_active;
			end else begin
				if (n >= limit) begin
					report_timeout("rx_done");
				end
				n++;
				@(negedge clk);
			end
		end
		check_value("rx_result.data", 32'(got.data), 32'(value));
		check_value("rx_result.parity", 32'(got.parity), 32'(parity_rule(value)));
		check_value("rx_result.parity_ok", 32'(got.parity_ok), 32'(bad_parity == 0));
		check_value("rx_result.frame_error", 32'(got.frame_error), 32'(bad_stop != 0));
		check_value("rx_active at rx_done", 32'(active_at_done), 32'd0);
		// Idle line before the next case
		repeat (2 * sym) @(negedge clk);
	endtask

	// Trigger one frame, decode tx mid-bit, optionally retrigger while busy
	task automatic run_tx_case(input int sym, input uart_data_t value, input logic busy);
		logic [11:0] decoded;
		logic [11:0] expected;
		int          limit;
		int          n;
		limit = 16 * sym + 32;
		expected = {2'b11, parity_rule(value), value, 1'b0};
		decoded = '0;
		tx_data = value;
		tx_trigger = 1'b1;
		@(negedge clk);
		tx_trigger = 1'b0;
		n = 0;
		while (tx !== 1'b0) begin
			if (n >= limit) begin
				report_timeout("tx start bit");
			end
			n++;
			@(negedge clk);
		end
		check_value("tx_active", 32'(tx_active), 32'd1);
		for (int cyc = 0; cyc < 12 * sym; cyc++) begin
			if (cyc % sym == sym / 2 + 1) begin
				decoded[cyc / sym] = tx;
			end
			if (busy && cyc == 3 * sym) begin
				check_value("tx_active at busy trigger", 32'(tx_active), 32'd1);
				tx_data = ~value;
				tx_trigger = 1'b1;
			end
			if (busy && cyc == 3 * sym + 1) begin
				tx_trigger = 1'b0;
			end
			check_value("tx_done", 32'(tx_done), 32'd0);
			@(negedge clk);
		end
		n = 0;
		while (tx_done !== 1'b1) begin
			if (n >= limit) begin
				report_timeout("tx_done");
			end
			n++;
			@(negedge clk);
		end
		check_value("tx_active at tx_done", 32'(tx_active), 32'd0);
		check_value("tx start bit", 32'(decoded[0]), 32'(expected[0]));
		check_value("tx data", 32'(decoded[8:1]), 32'(expected[8:1]));
		check_value("tx parity", 32'(decoded[9]), 32'(expected[9]));
		check_value("tx stop bits", 32'(decoded[11:10]), 32'(expected[11:10]));
		@(negedge clk);
		check_value("tx_done", 32'(tx_done), 32'd0);
		if (busy) begin
			// The dropped trigger must not start another frame
			for (int cyc = 0; cyc < 24 * sym; cyc++) begin
				check_value("tx", 32'(tx), 32'd1);
				check_value("tx_active", 32'(tx_active), 32'd0);
				check_value("tx_done", 32'(tx_done), 32'd0);
				@(negedge clk);
			end
		end else begin
			repeat (sym) @(negedge clk);
		end
	endtask

	initial begin
		clk = 1'b0;
		n_reset = 1'b1;
		clks_per_sym = sym_count_t'(4);
		rx = 1'b1;
		tx_data = '0;
		tx_trigger = 1'b0;
		case_num = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		n_reset = 1'b0;
		check_value("tx", 32'(tx), 32'd1);
		check_value("tx_active", 32'(tx_active), 32'd0);
		check_value("tx_done", 32'(tx_done), 32'd0);
		check_value("rx_active", 32'(rx_active), 32'd0);
		check_value("rx_done", 32'(rx_done), 32'd0);
		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the case file %s", CASE_FILE);
			abort_run();
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 3 || line.getc(0) == "#") begin
				continue;
			end
			fields = $sscanf(line, "%c %d %h %d %d", op, cps, data, pcor, scor);
			if (fields != 5) begin
				$display("Case line could not be read: %s", line);
				abort_run();
			end
			if (cps < 4) begin
				$display("Case %0d has a symbol length below 4", case_num + 1);
				abort_run();
			end
			case_num++;
			clks_per_sym = sym_count_t'(cps);
			@(negedge clk);
			case (op)
				"t": run_tx_case(cps, data, 1'b0);
				"r": run_rx_case(cps, data, pcor, scor);
				"b": run_tx_case(cps, data, 1'b1);
				default: begin
					$display("Case %0d has an unknown operation", case_num);
					abort_run();
				end
			endcase
		end
		$fclose(fd);
		$display("Cases run: %0d", case_num);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: tests/uart_cases.txt
# op clks_per_sym data(hex) parity_corrupt stop_corrupt
# op: t transmit, r receive, b second trigger while busy
t 4 a5 0 0
t 7 3c 0 0
t 16 00 0 0
t 9 ff 0 0
r 4 5a 0 0
r 8 81 0 0
r 16 00 0 0
r 11 ff 0 0
r 6 c3 1 0
r 13 7e 1 0
r 5 19 0 1
r 12 e4 0 1
r 10 66 1 1
b 4 96 0 0
b 14 2b 0 0
t 5 01 0 0
r 4 80 0 0
t 15 d2 0 0
r 9 4b 0 0

// File: uart_full_duplex.f
logic/uart_pkg.sv
logic/uart_symbol_timer.sv
logic/uart_receiver.sv
logic/uart_transmitter.sv
logic/uart_full_duplex.sv
tests/uart_full_duplex_sva.sv
tests/uart_full_duplex_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= uart_full_duplex_tb
FILELIST  ?= uart_full_duplex.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qxF "$(PASS_MSG)"; then \
		echo "sim: passed"; \
	else \
		echo "sim: failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
